// File: build.f
hdl/spi_ctrlport_pkg.sv
hdl/spi_byte_slave.sv
hdl/spi_byte_counter.sv
hdl/spi_frame_fsm.sv
hdl/spi_request_assembler.sv
hdl/spi_response_shifter.sv
hdl/ctrlport_reg_target.sv
hdl/spi_ctrlport_top.sv
verif/tb_clock_gen.sv
verif/spi_ctrlport_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the SPI to control-port bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module spi_ctrlport_tb -f build.f; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vspi_ctrlport_tb)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "^=== PASS ===$"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

// File: verif/spi_ctrlport_tb.sv
// Testbench for the SPI to control-port bridge
// Acts as SPI mode 0 master, keeps a model of the scratch registers
// and checks response bytes and read data against it

`timescale 1ns/1ps
`default_nettype none

module spi_ctrlport_tb;

  import spi_ctrlport_pkg::*;

  // SPI master timing in control-port clock cycles
  localparam int sclk_half    = 4;
  localparam int idle_cycles  = 8;
  localparam int frame_cycles = frame_bytes * 8 * 2 * sclk_half + idle_cycles + 2;
  localparam int pair_count   = 20;
  // Init writes, random pairs, id, unmapped, abort, readback, final sweep
  localparam int total_frames   = reg_count + 2 * pair_count + 6 + reg_count;
  localparam int timeout_cycles = (total_frames + 4) * frame_cycles;

  logic ctrlport_clk;
  logic ctrlport_rst;
  logic sclk;
  logic cs_n;
  logic mosi;
  logic miso;

  // Scratch register model
  logic [31:0] model [reg_count];
  integer      seed;
  int          cycle_count = 0;

  tb_clock_gen u_tb_clock_gen (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst)
  );

  spi_ctrlport_top u_spi_ctrlport_top (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .sclk         (sclk),
    .cs_n         (cs_n),
    .mosi         (mosi),
    .miso         (miso)
  );

  // Run length guard
  always @(posedge ctrlport_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
      abort_run("timeout");
    end
  end

  task automatic abort_run(input string reason);
    $display("=== FAIL ===");
    $fatal(1, "%s", reason);
  endtask

  task automatic compare_word(input string test, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s %s expected 0x%08h actual 0x%08h",
               test, field, expected, actual);
      abort_run($sformatf("%s %s mismatch", test, field));
    end
  endtask

  // Last frame byte holds 5 pad bits then ack and status
  function automatic logic [7:0] status_byte(input logic ack, input logic [1:0] sts);
    return {5'b00000, ack, sts};
  endfunction

  // ------------------------------
  // SPI master, mode 0, MSB first
  // ------------------------------
  // mosi changes while sclk is low and miso is taken at each rise
  task automatic shift_frame(input logic [63:0] tx_bits, input int n_bytes,
                             output logic [63:0] rx_bits);
    logic [63:0] tx_q;
    logic [63:0] rx_q;
    int          bit_num;
    tx_q = tx_bits;
    rx_q = '0;
    @(negedge ctrlport_clk);
    cs_n = 1'b0;
    for (bit_num = 0; bit_num < n_bytes * 8; bit_num++) begin
      mosi = tx_q[63];
      tx_q = {tx_q[62:0], 1'b0};
      repeat (sclk_half) @(negedge ctrlport_clk);
      sclk = 1'b1;
      rx_q = {rx_q[62:0], miso};
      repeat (sclk_half) @(negedge ctrlport_clk);
      sclk = 1'b0;
    end
    // Frame ends with the last sclk fall
    cs_n = 1'b1;
    mosi = 1'b0;
    repeat (idle_cycles) @(negedge ctrlport_clk);
    rx_bits = rx_q;
  endtask

  // Write frame sends flag, address, data and gap and gets the status byte back
  task automatic write_frame(input string test, input logic [14:0] addr,
                             input logic [31:0] data, input logic [1:0] exp_sts);
    logic [63:0] rx;
    shift_frame({1'b1, addr, data, 16'h0000}, frame_bytes, rx);
    compare_word(test, "status", {24'h000000, status_byte(1'b1, exp_sts)},
                 {24'h000000, rx[7:0]});
  endtask

  // Read frame sends flag, address and gap and gets four data bytes and the status byte
  task automatic read_frame(input string test, input logic [14:0] addr,
                            input logic [31:0] exp_data, input logic [1:0] exp_sts);
    logic [63:0] rx;
    shift_frame({1'b0, addr, 48'h0000_0000_0000}, frame_bytes, rx);
    compare_word(test, "data", exp_data, rx[39:8]);
    compare_word(test, "status", {24'h000000, status_byte(1'b1, exp_sts)},
                 {24'h000000, rx[7:0]});
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] data;
    logic [14:0] addr;
    logic [63:0] rx;
    logic [2:0]  idx;
    int          i;
    sclk = 1'b0;
    cs_n = 1'b1;
    mosi = 1'b0;
    seed = 50304;
    @(negedge ctrlport_clk);
    while (ctrlport_rst) @(negedge ctrlport_clk);
    repeat (4) @(negedge ctrlport_clk);

    // Fill every scratch register with a pattern tied to the whole index
    for (i = 0; i < reg_count; i++) begin
      idx  = 3'(i);
      data = {16'hc0de, 13'h0000, idx};
      write_frame($sformatf("init write reg %0d", i), {12'h000, idx}, data, sts_okay);
      model[idx] = data;
    end

    // Random write then read-back pairs
    for (i = 0; i < pair_count; i++) begin
      rnd  = $random(seed);
      idx  = rnd[2:0];
      data = $random(seed);
      write_frame($sformatf("pair %0d write", i), {12'h000, idx}, data, sts_okay);
      model[idx] = data;
      read_frame($sformatf("pair %0d read", i), {12'h000, idx}, model[idx], sts_okay);
    end

    // ------------------------------
    // Identity word
    // ------------------------------
    read_frame("id read", id_addr[14:0], id_value, sts_okay);
    // Write to the read-only word is refused with cmderr
    write_frame("id write", id_addr[14:0], 32'hdead_beef, sts_cmderr);

    // No ack from an unmapped address so the default answer comes back
    rnd  = $random(seed);
    addr = rnd[14:0] | 15'h0100;
    read_frame("unmapped read", addr, 32'h0000_0000, sts_cmderr);
    write_frame("unmapped write", addr, rnd, sts_cmderr);

    // Write to reg 5 cut after 3 bytes before the strobe
    shift_frame({1'b1, 15'h0005, ~model[5], 16'h0000}, 3, rx);
    read_frame("read after abort", 15'h0005, model[5], sts_okay);

    // Nothing else disturbed the scratch registers
    for (i = 0; i < reg_count; i++) begin
      idx = 3'(i);
      read_frame($sformatf("sweep reg %0d", i), {12'h000, idx}, model[idx], sts_okay);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/tb_clock_gen.sv
// Testbench clock and reset source
// 8 ns control-port clock, reset held high for the first 5 cycles

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic ctrlport_clk,
  output logic ctrlport_rst
);

  localparam int half_period_ns = 4;
  localparam int reset_cycles   = 5;

  initial begin
    ctrlport_clk = 1'b0;
    forever #(half_period_ns) ctrlport_clk = ~ctrlport_clk;
  end

  // Release on a falling edge, away from the DUT sampling edge
  initial begin
    ctrlport_rst = 1'b1;
    repeat (reset_cycles) @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    ctrlport_rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: hdl/spi_ctrlport_top.sv
// SPI to control-port bridge with its register target
// Only the SPI pins leave the block

`timescale 1ns/1ps
`default_nettype none

module spi_ctrlport_top (
  input  logic ctrlport_clk,
  input  logic ctrlport_rst,
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  import spi_ctrlport_pkg::*;

  // SPI byte interface
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       tx_required;
  logic       tx_valid;
  logic [7:0] tx_byte;
  logic       active;

  // Frame control
  logic                  frame_clear;
  logic [byte_idx_w-1:0] byte_idx;
  logic                  is_write;
  logic                  resp_window;
  logic                  provide_response;

  // ------------------------------
  // Control-port wires
  // ------------------------------
  logic                       req_wr;
  logic                       req_rd;
  logic [ctrlport_addr_w-1:0] req_addr;
  logic [ctrlport_data_w-1:0] req_data;
  logic                       resp_ack;
  logic [1:0]                 resp_status;
  logic [ctrlport_data_w-1:0] resp_data;

  spi_byte_slave u_spi_byte_slave (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .sclk         (sclk),
    .cs_n         (cs_n),
    .mosi         (mosi),
    .miso         (miso),
    .rx_valid     (rx_valid),
    .rx_byte      (rx_byte),
    .tx_required  (tx_required),
    .tx_valid     (tx_valid),
    .tx_byte      (tx_byte),
    .active       (active)
  );

  spi_byte_counter u_spi_byte_counter (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .frame_clear  (frame_clear),
    .rx_valid     (rx_valid),
    .byte_idx     (byte_idx)
  );

  // Read or write flag is the MSB of byte 0
  spi_frame_fsm u_spi_frame_fsm (
    .ctrlport_clk     (ctrlport_clk),
    .ctrlport_rst     (ctrlport_rst),
    .active           (active),
    .rx_valid         (rx_valid),
    .rx_msb           (rx_byte[7]),
    .byte_idx         (byte_idx),
    .tx_required      (tx_required),
    .frame_clear      (frame_clear),
    .is_write         (is_write),
    .req_wr           (req_wr),
    .req_rd           (req_rd),
    .resp_window      (resp_window),
    .provide_response (provide_response)
  );

  spi_request_assembler u_spi_request_assembler (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .rx_valid     (rx_valid),
    .rx_byte      (rx_byte),
    .is_write     (is_write),
    .req_addr     (req_addr),
    .req_data     (req_data)
  );

  spi_response_shifter u_spi_response_shifter (
    .ctrlport_clk     (ctrlport_clk),
    .ctrlport_rst     (ctrlport_rst),
    .frame_clear      (frame_clear),
    .is_write         (is_write),
    .req_strobe       (req_wr | req_rd),
    .resp_window      (resp_window),
    .resp_ack         (resp_ack),
    .resp_status      (resp_status),
    .resp_data        (resp_data),
    .tx_required      (tx_required),
    .provide_response (provide_response),
    .tx_valid         (tx_valid),
    .tx_byte          (tx_byte)
  );

  ctrlport_reg_target u_ctrlport_reg_target (
    .ctrlport_clk (ctrlport_clk),
    .ctrlport_rst (ctrlport_rst),
    .req_wr       (req_wr),
    .req_rd       (req_rd),
    .req_addr     (req_addr),
    .req_data     (req_data),
    .resp_ack     (resp_ack),
    .resp_status  (resp_status),
    .resp_data    (resp_data)
  );

endmodule

`default_nettype wire

// File: hdl/ctrlport_reg_target.sv
// Control-port register target behind the SPI bridge
// Eight scratch registers plus a read-only identity word
// Acks one cycle after a strobe, unmapped addresses get no ack

`timescale 1ns/1ps
`default_nettype none

module ctrlport_reg_target (
  input  logic                                        ctrlport_clk,
  input  logic                                        ctrlport_rst,
  input  logic                                        req_wr,
  input  logic                                        req_rd,
  input  logic [spi_ctrlport_pkg::ctrlport_addr_w-1:0] req_addr,
  input  logic [spi_ctrlport_pkg::ctrlport_data_w-1:0] req_data,
  output logic                                        resp_ack,
  output logic [1:0]                                  resp_status,
  output logic [spi_ctrlport_pkg::ctrlport_data_w-1:0] resp_data
);

  import spi_ctrlport_pkg::*;

  logic [ctrlport_data_w-1:0]   scratch [reg_count];
  logic [$clog2(reg_count)-1:0] reg_sel;
  logic                         hit_scratch;
  logic                         hit_id;

  assign reg_sel     = req_addr[$clog2(reg_count)-1:0];
  assign hit_scratch = (req_addr < ctrlport_addr_w'(reg_count));
  assign hit_id      = (req_addr == id_addr);

  // ------------------------------
  // Ack and status
  // ------------------------------
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      resp_ack    <= 1'b0;
      resp_status <= sts_okay;
    end else begin
      resp_ack    <= (req_wr || req_rd) && (hit_scratch || hit_id);
      // Identity word is read-only
      resp_status <= (req_wr && hit_id) ? sts_cmderr : sts_okay;
    end
  end

  // Scratch storage and read data
  always_ff @(posedge ctrlport_clk) begin
    if (req_wr && hit_scratch) begin
      scratch[reg_sel] <= req_data;
    end
    if (req_rd && hit_scratch) begin
      resp_data <= scratch[reg_sel];
    end else if (req_rd && hit_id) begin
      resp_data <= id_value;
    end else begin
      resp_data <= '0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_response_shifter.sv
// Response shifter for the SPI bridge
// Loads the default CMDERR answer at the strobe, replaces it with the
// target's answer while the ack window is open, then hands one byte
// per byte start to the SPI slave

`timescale 1ns/1ps
`default_nettype none

module spi_response_shifter (
  input  logic                                        ctrlport_clk,
  input  logic                                        ctrlport_rst,
  input  logic                                        frame_clear,
  input  logic                                        is_write,
  input  logic                                        req_strobe,
  input  logic                                        resp_window,
  input  logic                                        resp_ack,
  input  logic [1:0]                                  resp_status,
  input  logic [spi_ctrlport_pkg::ctrlport_data_w-1:0] resp_data,
  input  logic                                        tx_required,
  input  logic                                        provide_response,
  output logic                                        tx_valid,
  output logic [7:0]                                  tx_byte
);

  import spi_ctrlport_pkg::*;

  logic [resp_bytes*8-1:0] resp_q;
  logic                    shift_out;

  assign shift_out = tx_required & provide_response;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst || frame_clear) begin
      resp_q <= '0;
    end else begin
      if (req_strobe) begin
        // Default answer, ack set with CMDERR and zero data
        if (is_write) begin
          // Status byte leads, data bytes unused
          resp_q <= {5'b0, 1'b1, sts_cmderr, {ctrlport_data_w{1'b0}}};
        end else begin
          // Data first, status byte closes the frame
          resp_q <= {{ctrlport_data_w{1'b0}}, 5'b0, 1'b1, sts_cmderr};
        end
      end else if (resp_window && resp_ack) begin
        if (is_write) begin
          resp_q <= {5'b0, resp_ack, resp_status, {ctrlport_data_w{1'b0}}};
        end else begin
          resp_q <= {resp_data, 5'b0, resp_ack, resp_status};
        end
      end

      // Byte handed over, move the next one to the top
      if (shift_out) begin
        resp_q <= {resp_q[(resp_bytes-1)*8-1:0], 8'h00};
      end
    end
  end

  // Answer in the same cycle as the request from the slave
  assign tx_valid = shift_out;
  assign tx_byte  = resp_q[resp_bytes*8-1 -: 8];

endmodule

`default_nettype wire

// File: hdl/spi_request_assembler.sv
// Request assembler for the SPI bridge
// Shifts received bytes into the request word and presents the
// control-port address and data through the write or read view

`timescale 1ns/1ps
`default_nettype none

module spi_request_assembler (
  input  logic                                        ctrlport_clk,
  input  logic                                        ctrlport_rst,
  input  logic                                        rx_valid,
  input  logic [7:0]                                  rx_byte,
  input  logic                                        is_write,
  output logic [spi_ctrlport_pkg::ctrlport_addr_w-1:0] req_addr,
  output logic [spi_ctrlport_pkg::ctrlport_data_w-1:0] req_data
);

  import spi_ctrlport_pkg::*;

  spi_request_u req_q;

  // Oldest byte drops off the top, newest enters at the bottom
  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      req_q <= '0;
    end else if (rx_valid) begin
      req_q <= {req_q[wr_req_bytes*8-9:0], rx_byte};
    end
  end

  // ------------------------------
  // Decode
  // ------------------------------
  // Upper address bits are not carried on SPI
  assign req_addr = is_write ?
                    {{(ctrlport_addr_w - spi_addr_w){1'b0}}, req_q.wr.addr} :
                    {{(ctrlport_addr_w - spi_addr_w){1'b0}}, req_q.rd.addr};

  // Only meaningful with req_wr
  assign req_data = req_q.wr.data;

endmodule

`default_nettype wire

// File: hdl/spi_frame_fsm.sv
// Frame sequencer for the SPI bridge
// Latches read or write from byte 0, fires one control-port strobe at
// the end of the request, holds the ack window over the gap byte and
// enables the response bytes up to the end of the frame

`timescale 1ns/1ps
`default_nettype none

module spi_frame_fsm (
  input  logic                                  ctrlport_clk,
  input  logic                                  ctrlport_rst,
  input  logic                                  active,
  input  logic                                  rx_valid,
  input  logic                                  rx_msb,
  input  logic [spi_ctrlport_pkg::byte_idx_w-1:0] byte_idx,
  input  logic                                  tx_required,
  output logic                                  frame_clear,
  output logic                                  is_write,
  output logic                                  req_wr,
  output logic                                  req_rd,
  output logic                                  resp_window,
  output logic                                  provide_response
);

  import spi_ctrlport_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_gap,
    st_response
  } state_t;

  state_t state;
  logic   active_d;
  logic   frame_end;
  logic   last_req;

  // cs_n rising, seen as the fall of active
  assign frame_end = active_d & ~active;

  // Last request byte differs between write and read
  assign last_req = rx_valid &&
                    (byte_idx == (is_write ? byte_idx_w'(wr_req_bytes - 1) :
                                             byte_idx_w'(rd_req_bytes - 1)));

  // Window opens with the strobe, shuts at the first response byte
  assign resp_window      = (state == st_gap);
  assign provide_response = (state == st_gap) || (state == st_response);

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      state       <= st_idle;
      active_d    <= 1'b0;
      frame_clear <= 1'b0;
      is_write    <= 1'b0;
      req_wr      <= 1'b0;
      req_rd      <= 1'b0;
    end else begin
      active_d    <= active;
      frame_clear <= frame_end;
      // Strobes are single-cycle
      req_wr      <= 1'b0;
      req_rd      <= 1'b0;

      if (frame_end) begin
        state    <= st_idle;
        is_write <= 1'b0;
      end else begin
        case (state)
          st_idle: begin
            if (rx_valid && (byte_idx == '0)) begin
              is_write <= rx_msb;
              state    <= st_request;
            end
          end
          st_request: begin
            if (last_req) begin
              req_wr <= is_write;
              req_rd <= ~is_write;
              state  <= st_gap;
            end
          end
          // First tx_required here starts the response
          st_gap: begin
            if (tx_required) begin
              state <= st_response;
            end
          end
          default: begin
            if (rx_valid && (byte_idx == byte_idx_w'(frame_bytes - 1))) begin
              state <= st_idle;
            end
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_byte_counter.sv
// Byte position counter for one SPI frame
// Counts received bytes, wraps after the last byte, cleared at frame end

`timescale 1ns/1ps
`default_nettype none

module spi_byte_counter (
  input  logic                                  ctrlport_clk,
  input  logic                                  ctrlport_rst,
  input  logic                                  frame_clear,
  input  logic                                  rx_valid,
  output logic [spi_ctrlport_pkg::byte_idx_w-1:0] byte_idx
);

  import spi_ctrlport_pkg::*;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst || frame_clear) begin
      byte_idx <= '0;
    end else if (rx_valid) begin
      // Explicit wrap, frame is exactly frame_bytes long
      if (byte_idx == byte_idx_w'(frame_bytes - 1)) begin
        byte_idx <= '0;
      end else begin
        byte_idx <= byte_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_byte_slave.sv
// SPI mode 0 byte slave, oversampled in the control-port clock domain
// Samples mosi on sclk rise, drives miso on sclk fall, MSB first
// Asks for a transmit byte at the start of every byte of the frame

`timescale 1ns/1ps
`default_nettype none

module spi_byte_slave (
  input  logic       ctrlport_clk,
  input  logic       ctrlport_rst,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic       rx_valid,
  output logic [7:0] rx_byte,
  output logic       tx_required,
  input  logic       tx_valid,
  input  logic [7:0] tx_byte,
  output logic       active
);

  // Two-flop synchronizers, sclk gets a third stage for edge detect
  logic [1:0] sclk_sync;
  logic [1:0] cs_n_sync;
  logic [1:0] mosi_sync;
  logic       sclk_d;
  logic       active_d;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       frame_start;
  logic       byte_done;
  logic       first_byte;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic [7:0] load_byte;

  assign active      = ~cs_n_sync[1];
  assign sclk_rise   = sclk_sync[1] & ~sclk_d;
  assign sclk_fall   = ~sclk_sync[1] & sclk_d;
  assign frame_start = active & ~active_d;
  // Eighth rise of the byte
  assign byte_done   = active & sclk_rise & (bit_cnt == 3'd7);
  // Zeros go out when the shifter has nothing to send
  assign load_byte   = tx_valid ? tx_byte : 8'h00;
  // Stable until the next sclk rise
  assign rx_byte     = rx_shift;

  always_ff @(posedge ctrlport_clk) begin
    if (ctrlport_rst) begin
      sclk_sync   <= 2'b00;
      cs_n_sync   <= 2'b11;
      mosi_sync   <= 2'b00;
      sclk_d      <= 1'b0;
      active_d    <= 1'b0;
      bit_cnt     <= 3'd0;
      rx_shift    <= 8'h00;
      rx_valid    <= 1'b0;
      tx_required <= 1'b0;
      first_byte  <= 1'b0;
      tx_shift    <= 8'h00;
      miso        <= 1'b0;
    end else begin
      sclk_sync   <= {sclk_sync[0], sclk};
      cs_n_sync   <= {cs_n_sync[0], cs_n};
      mosi_sync   <= {mosi_sync[0], mosi};
      sclk_d      <= sclk_sync[1];
      active_d    <= active;
      rx_valid    <= byte_done;
      // Byte start, either frame start or previous byte complete
      tx_required <= frame_start | byte_done;
      first_byte  <= frame_start;

      // Receive side
      if (!active) begin
        bit_cnt <= 3'd0;
      end else if (sclk_rise) begin
        bit_cnt  <= bit_cnt + 3'd1;
        rx_shift <= {rx_shift[6:0], mosi_sync[1]};
      end

      // ------------------------------
      // Transmit side
      // ------------------------------
      if (!active) begin
        miso <= 1'b0;
      end else if (tx_required) begin
        if (first_byte) begin
          // No fall before the first rise, MSB goes out right away
          miso     <= load_byte[7];
          tx_shift <= {load_byte[6:0], 1'b0};
        end else begin
          // MSB waits for the fall after the last rise
          tx_shift <= load_byte;
        end
      end else if (sclk_fall) begin
        miso     <= tx_shift[7];
        tx_shift <= {tx_shift[6:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_ctrlport_pkg.sv
// SPI to control-port bridge definitions
// Frame sizes, control-port status codes, register map of the target
// and the request word with its write and read views

`default_nettype none

package spi_ctrlport_pkg;

  // Control-port widths
  localparam int ctrlport_addr_w = 20;
  localparam int ctrlport_data_w = 32;

  // ------------------------------
  // SPI frame format
  // ------------------------------
  localparam int spi_addr_w   = 15;
  localparam int frame_bytes  = 8;
  localparam int wr_req_bytes = 6;
  localparam int rd_req_bytes = 2;
  localparam int resp_bytes   = 5;
  localparam int byte_idx_w   = 3;

  // Control-port status codes
  localparam logic [1:0] sts_okay    = 2'd0;
  localparam logic [1:0] sts_cmderr  = 2'd1;
  localparam logic [1:0] sts_tserr   = 2'd2;
  localparam logic [1:0] sts_addrerr = 2'd3;

  // ------------------------------
  // Register target map
  // ------------------------------
  localparam int                         reg_count = 8;
  localparam logic [ctrlport_addr_w-1:0] id_addr   = 20'h00010;
  localparam logic [ctrlport_data_w-1:0] id_value  = 32'h5350_4331;

  // Write view, whole six-byte request
  typedef struct packed {
    logic                       wr_flag;
    logic [spi_addr_w-1:0]      addr;
    logic [ctrlport_data_w-1:0] data;
  } spi_wr_view_t;

  // Read view, request sits in the last two bytes received
  typedef struct packed {
    logic [ctrlport_data_w-1:0] unused;
    logic                       rd_flag;
    logic [spi_addr_w-1:0]      addr;
  } spi_rd_view_t;

  // Request shift register, decoded one way or the other
  typedef union packed {
    spi_wr_view_t wr;
    spi_rd_view_t rd;
  } spi_request_u;

endpackage

`default_nettype wire
